//--- tb.f
+incdir+include
source/nib_pkg.sv
source/core_owner_arb.sv
source/port_crossbar.sv
source/nib_top.sv
sim/tb_nib.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the nib testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_nib -f tb.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_nib 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "All checks passed"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi

//--- include/tb_nib_ref.svh
//**********************************************************
// nib testbench reference model
// slave responses, sticky ownership rule, expected outputs
// and the lfsr used for random stimulus
//**********************************************************

`ifndef TB_NIB_REF_SVH
`define TB_NIB_REF_SVH

// per slave read keys, 0 mem, 1 instr nvm, 2 scalar nvm
localparam logic [NIB_DATA_W-1:0] MEM_RD_KEY    = 32'hA5A5_0F0F;
localparam logic [NIB_DATA_W-1:0] INSTR_RD_KEY  = 32'h3C3C_F00D;
localparam logic [NIB_DATA_W-1:0] SCALAR_RD_KEY = 32'h5A00_C3E1;

// slave answers in the same cycle, address xor its key
function automatic logic [NIB_DATA_W-1:0] slave_rd_data(input int slave,
                                                        input logic [NIB_ADDR_W-1:0] a);
    case (slave)
        0:       return NIB_DATA_W'(a) ^ MEM_RD_KEY;
        1:       return NIB_DATA_W'(a) ^ INSTR_RD_KEY;
        default: return NIB_DATA_W'(a) ^ SCALAR_RD_KEY;
    endcase
endfunction

// last owner wins if it asks, else the other core, else idle
function automatic void owner_rule(input core_idx_t last, input logic c0_any,
                                   input logic c1_any, output core_idx_t owner,
                                   output logic busy);
    logic last_any;
    logic other_any;
    last_any  = (last == CORE_0) ? c0_any : c1_any;
    other_any = (last == CORE_0) ? c1_any : c0_any;
    owner = last;
    busy  = last_any || other_any;
    if (!last_any && other_any) begin
        owner = (last == CORE_0) ? CORE_1 : CORE_0;
    end
endfunction

// every bus output for one set of master inputs
function automatic void expected_outputs(
    input  core_idx_t                        last,
    input  logic [1:0][2:0]                  r,
    input  logic [1:0][2:0][NIB_ADDR_W-1:0]  a,
    input  logic [1:0]                       we,
    input  logic [1:0][NIB_DATA_W-1:0]       wd,
    output logic [2:0]                       s_req,
    output logic [2:0][NIB_ADDR_W-1:0]       s_addr,
    output logic                             s_wr_en,
    output logic [NIB_DATA_W-1:0]            s_wr_data,
    output logic [1:0][2:0][NIB_DATA_W-1:0]  rd,
    output logic [1:0]                       hold
);
    core_idx_t owner;
    logic      busy;
    owner_rule(last, |r[0], |r[1], owner, busy);
    s_req     = '0;
    s_addr    = '0;
    s_wr_en   = 1'b0;
    s_wr_data = '0;
    rd        = '0;
    if (busy) begin
        s_req     = r[owner];
        s_wr_en   = we[owner];
        s_wr_data = wd[owner];
        for (int p = 0; p < 3; p++) begin
            s_addr[p]    = a[owner][p];
            rd[owner][p] = slave_rd_data(p, a[owner][p]);
        end
    end
    // requesting but not owner means stall
    hold[0] = (|r[0]) && (owner != CORE_0);
    hold[1] = (|r[1]) && (owner != CORE_1);
endfunction

// fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
endfunction

`endif

//--- sim/tb_nib.sv
//**********************************************************
// nib shared bus testbench
// directed and random traffic on both cores, checked every
// cycle against the reference model
//**********************************************************

`timescale 1ns/100ps

module tb_nib;
    import nib_pkg::*;

    `include "tb_nib_ref.svh"

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 16;
    localparam int DIRECTED_CYCLES = 30;
    localparam int RANDOM_CYCLES   = 400;
    localparam int TOTAL_CYCLES    = 2 * RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;
    localparam int TIMEOUT_NS      = (TOTAL_CYCLES + 50) * CLK_PERIOD;

    logic clk;
    logic rstn;
    // master stimulus by core and port (data 0, instr 1, scalar 2)
    logic [1:0][2:0]                 req;
    logic [1:0][2:0][NIB_ADDR_W-1:0] addr;
    logic [1:0]                      wr_en;
    logic [1:0][NIB_DATA_W-1:0]      wr_data;

    logic [NIB_DATA_W-1:0] c0_data_rd;
    logic [NIB_DATA_W-1:0] c0_instr_rd;
    logic [NIB_DATA_W-1:0] c0_scalar_rd;
    logic [NIB_DATA_W-1:0] c1_data_rd;
    logic [NIB_DATA_W-1:0] c1_instr_rd;
    logic [NIB_DATA_W-1:0] c1_scalar_rd;
    logic                  c0_hold;
    logic                  c1_hold;
    logic                  mem_req;
    logic                  instr_req;
    logic                  scalar_req;
    logic                  mem_wr_en;
    logic [NIB_ADDR_W-1:0] mem_addr;
    logic [NIB_ADDR_W-1:0] instr_addr;
    logic [NIB_ADDR_W-1:0] scalar_addr;
    logic [NIB_DATA_W-1:0] mem_wr_data;
    logic [NIB_DATA_W-1:0] mem_rd;
    logic [NIB_DATA_W-1:0] instr_rd;
    logic [NIB_DATA_W-1:0] scalar_rd;

    // expected values and the testbench copy of the owner register
    logic [2:0]                      exp_s_req;
    logic [2:0][NIB_ADDR_W-1:0]      exp_s_addr;
    logic                            exp_wr_en;
    logic [NIB_DATA_W-1:0]           exp_wr_data;
    logic [1:0][2:0][NIB_DATA_W-1:0] exp_rd;
    logic [1:0]                      exp_hold;
    core_idx_t                       ref_last_owner;
    logic [15:0]                     lfsr_state;
    string                           test_name;

    nib_top #(.ADDR_W(NIB_ADDR_W), .DATA_W(NIB_DATA_W)) nib_top_i (
        .clk (clk), .rstn (rstn),
        .c0_data_req_i (req[0][0]), .c0_data_addr_i (addr[0][0]),
        .c0_data_wr_en_i (wr_en[0]), .c0_data_wr_data_i (wr_data[0]),
        .c0_data_rd_data_o (c0_data_rd),
        .c0_instr_req_i (req[0][1]), .c0_instr_addr_i (addr[0][1]),
        .c0_instr_rd_data_o (c0_instr_rd),
        .c0_scalar_req_i (req[0][2]), .c0_scalar_addr_i (addr[0][2]),
        .c0_scalar_rd_data_o (c0_scalar_rd), .c0_hold_o (c0_hold),
        .c1_data_req_i (req[1][0]), .c1_data_addr_i (addr[1][0]),
        .c1_data_wr_en_i (wr_en[1]), .c1_data_wr_data_i (wr_data[1]),
        .c1_data_rd_data_o (c1_data_rd),
        .c1_instr_req_i (req[1][1]), .c1_instr_addr_i (addr[1][1]),
        .c1_instr_rd_data_o (c1_instr_rd),
        .c1_scalar_req_i (req[1][2]), .c1_scalar_addr_i (addr[1][2]),
        .c1_scalar_rd_data_o (c1_scalar_rd), .c1_hold_o (c1_hold),
        .mem_req_o (mem_req), .mem_addr_o (mem_addr), .mem_wr_en_o (mem_wr_en),
        .mem_wr_data_o (mem_wr_data), .mem_rd_data_i (mem_rd),
        .instr_nvm_req_o (instr_req), .instr_nvm_addr_o (instr_addr),
        .instr_nvm_rd_data_i (instr_rd),
        .scalar_nvm_req_o (scalar_req), .scalar_nvm_addr_o (scalar_addr),
        .scalar_nvm_rd_data_i (scalar_rd)
    );

    // slaves answer combinationally
    assign mem_rd    = slave_rd_data(0, mem_addr);
    assign instr_rd  = slave_rd_data(1, instr_addr);
    assign scalar_rd = slave_rd_data(2, scalar_addr);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare_value(input string what, input logic [NIB_DATA_W-1:0] exp_v,
                                 input logic [NIB_DATA_W-1:0] act_v);
        assert (exp_v === act_v) else begin
            $display("[ERROR] %s: %s expected %h actual %h", test_name, what, exp_v, act_v);
            $display("Checks failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_outputs();
        expected_outputs(ref_last_owner, req, addr, wr_en, wr_data, exp_s_req, exp_s_addr,
                         exp_wr_en, exp_wr_data, exp_rd, exp_hold);
        compare_value("mem_req_o", NIB_DATA_W'(exp_s_req[0]), NIB_DATA_W'(mem_req));
        compare_value("instr_nvm_req_o", NIB_DATA_W'(exp_s_req[1]), NIB_DATA_W'(instr_req));
        compare_value("scalar_nvm_req_o", NIB_DATA_W'(exp_s_req[2]), NIB_DATA_W'(scalar_req));
        compare_value("mem_addr_o", NIB_DATA_W'(exp_s_addr[0]), NIB_DATA_W'(mem_addr));
        compare_value("instr_nvm_addr_o", NIB_DATA_W'(exp_s_addr[1]), NIB_DATA_W'(instr_addr));
        compare_value("scalar_nvm_addr_o", NIB_DATA_W'(exp_s_addr[2]),
                      NIB_DATA_W'(scalar_addr));
        compare_value("mem_wr_en_o", NIB_DATA_W'(exp_wr_en), NIB_DATA_W'(mem_wr_en));
        compare_value("mem_wr_data_o", exp_wr_data, mem_wr_data);
        compare_value("c0_data_rd_data_o", exp_rd[0][0], c0_data_rd);
        compare_value("c0_instr_rd_data_o", exp_rd[0][1], c0_instr_rd);
        compare_value("c0_scalar_rd_data_o", exp_rd[0][2], c0_scalar_rd);
        compare_value("c1_data_rd_data_o", exp_rd[1][0], c1_data_rd);
        compare_value("c1_instr_rd_data_o", exp_rd[1][1], c1_instr_rd);
        compare_value("c1_scalar_rd_data_o", exp_rd[1][2], c1_scalar_rd);
        compare_value("c0_hold_o", NIB_DATA_W'(exp_hold[0]), NIB_DATA_W'(c0_hold));
        compare_value("c1_hold_o", NIB_DATA_W'(exp_hold[1]), NIB_DATA_W'(c1_hold));
    endtask

    // compare just before the rising edge and then mirror the owner register
    always begin
        core_idx_t owner;
        logic      busy;
        @(negedge clk);
        #(CLK_PERIOD / 2 - 1);
        check_outputs();
        owner_rule(ref_last_owner, |req[0], |req[1], owner, busy);
        if (!rstn) begin
            ref_last_owner = CORE_0;
        end else if (busy) begin
            ref_last_owner = owner;
        end
    end

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic clear_inputs();
        req     = '0;
        addr    = '0;
        wr_en   = '0;
        wr_data = '0;
    endtask

    task automatic apply_reset();
        rstn = 1'b0;
        clear_inputs();
        repeat (RESET_CYCLES) @(negedge clk);
        rstn = 1'b1;
    endtask

    task automatic drive_port(input int c, input int p, input logic [NIB_ADDR_W-1:0] a);
        req[c][p]  = 1'b1;
        addr[c][p] = a;
    endtask

    // all three ports of a core with addresses a word apart
    task automatic request_all(input int c, input logic [NIB_ADDR_W-1:0] base);
        for (int p = 0; p < 3; p++) begin
            drive_port(c, p, base + NIB_ADDR_W'(4 * p));
        end
    endtask

    task automatic random_inputs();
        logic [31:0] v;
        for (int c = 0; c < 2; c++) begin
            for (int p = 0; p < 3; p++) begin
                v = rand_bits(1);
                req[c][p] = v[0];
                addr[c][p] = NIB_ADDR_W'(rand_bits(32));
            end
            v = rand_bits(1);
            wr_en[c] = v[0];
            wr_data[c] = NIB_DATA_W'(rand_bits(32));
        end
    endtask

    // watchdog sized from the cycle count of all tests
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog timeout, the run did not end within %0d ns", TIMEOUT_NS);
        $display("Checks failed");
        $fatal(1, "timeout");
    end

    initial begin
        clk            = 1'b0;
        lfsr_state     = 16'd7577;
        ref_last_owner = CORE_0;
        test_name      = "reset_idle";
        apply_reset();
        repeat (3) @(negedge clk);

        // core 1 alone with one port per cycle
        test_name = "single_core";
        drive_port(1, 0, 32'h0000_1000);
        @(negedge clk);
        clear_inputs();
        drive_port(1, 1, 32'h0000_2004);
        @(negedge clk);
        clear_inputs();
        drive_port(1, 2, 32'h0000_3008);
        @(negedge clk);
        clear_inputs();
        drive_port(1, 0, 32'h0000_1010);
        wr_en[1]   = 1'b1;
        wr_data[1] = 32'hCAFE_0001;
        @(negedge clk);
        clear_inputs();
        @(negedge clk);

        // fresh reset so core 0 is the last owner
        test_name = "contention";
        apply_reset();
        request_all(0, 32'h0000_0100);
        request_all(1, 32'h0000_0900);
        wr_en[0]   = 1'b1;
        wr_data[0] = 32'h1234_5678;
        #1;
        compare_value("c1_hold_o direct", 32'd1, NIB_DATA_W'(c1_hold));
        repeat (3) @(negedge clk);
        // core 0 keeps the bus on its instr port alone
        req[0] = 3'b010;
        repeat (2) @(negedge clk);

        // core 1 takes over in the same cycle
        test_name = "handover";
        req[0] = 3'b000;
        #1;
        compare_value("c1_hold_o direct", 32'd0, NIB_DATA_W'(c1_hold));
        @(negedge clk);
        clear_inputs();
        @(negedge clk);
        request_all(0, 32'h0000_0200);
        request_all(1, 32'h0000_0A00);
        #1;
        compare_value("c0_hold_o direct", 32'd1, NIB_DATA_W'(c0_hold));
        repeat (2) @(negedge clk);
        clear_inputs();
        @(negedge clk);

        test_name = "random";
        repeat (RANDOM_CYCLES) begin
            random_inputs();
            @(negedge clk);
        end
        clear_inputs();
        @(negedge clk);

        $display("All checks passed");
        $finish;
    end

endmodule

//--- source/nib_top.sv
//**********************************************************
// nib shared bus top
// two cores with data, instr and scalar ports onto the data
// memory, the instruction nvm and the scalar nvm
//**********************************************************

`timescale 1ns/100ps

module nib_top #(
    parameter int ADDR_W = nib_pkg::NIB_ADDR_W,
    parameter int DATA_W = nib_pkg::NIB_DATA_W
) (
    input  logic              clk,
    input  logic              rstn,

    // core 0 ports
    input  logic              c0_data_req_i,
    input  logic [ADDR_W-1:0] c0_data_addr_i,
    input  logic              c0_data_wr_en_i,
    input  logic [DATA_W-1:0] c0_data_wr_data_i,
    output logic [DATA_W-1:0] c0_data_rd_data_o,
    input  logic              c0_instr_req_i,
    input  logic [ADDR_W-1:0] c0_instr_addr_i,
    output logic [DATA_W-1:0] c0_instr_rd_data_o,
    input  logic              c0_scalar_req_i,
    input  logic [ADDR_W-1:0] c0_scalar_addr_i,
    output logic [DATA_W-1:0] c0_scalar_rd_data_o,
    output logic              c0_hold_o,

    // core 1 ports
    input  logic              c1_data_req_i,
    input  logic [ADDR_W-1:0] c1_data_addr_i,
    input  logic              c1_data_wr_en_i,
    input  logic [DATA_W-1:0] c1_data_wr_data_i,
    output logic [DATA_W-1:0] c1_data_rd_data_o,
    input  logic              c1_instr_req_i,
    input  logic [ADDR_W-1:0] c1_instr_addr_i,
    output logic [DATA_W-1:0] c1_instr_rd_data_o,
    input  logic              c1_scalar_req_i,
    input  logic [ADDR_W-1:0] c1_scalar_addr_i,
    output logic [DATA_W-1:0] c1_scalar_rd_data_o,
    output logic              c1_hold_o,

    // data memory
    output logic              mem_req_o,
    output logic [ADDR_W-1:0] mem_addr_o,
    output logic              mem_wr_en_o,
    output logic [DATA_W-1:0] mem_wr_data_o,
    input  logic [DATA_W-1:0] mem_rd_data_i,
    // instruction nvm, read only
    output logic              instr_nvm_req_o,
    output logic [ADDR_W-1:0] instr_nvm_addr_o,
    input  logic [DATA_W-1:0] instr_nvm_rd_data_i,
    // scalar nvm, read only
    output logic              scalar_nvm_req_o,
    output logic [ADDR_W-1:0] scalar_nvm_addr_o,
    input  logic [DATA_W-1:0] scalar_nvm_rd_data_i
);
    import nib_pkg::*;

    logic [2:0] c0_req_vec;
    logic [2:0] c1_req_vec;
    core_idx_t  owner;
    logic       busy;

    // request levels per core, data in bit 0
    assign c0_req_vec = {c0_scalar_req_i, c0_instr_req_i, c0_data_req_i};
    assign c1_req_vec = {c1_scalar_req_i, c1_instr_req_i, c1_data_req_i};

    // whole-core ownership, the only state on the bus
    core_owner_arb u_core_owner_arb (
        .clk          (clk),
        .rstn         (rstn),
        .c0_req_vec_i (c0_req_vec),
        .c1_req_vec_i (c1_req_vec),
        .owner_o      (owner),
        .busy_o       (busy),
        .c0_hold_o    (c0_hold_o),
        .c1_hold_o    (c1_hold_o)
    );

    // combinational routing, same cycle as the request
    port_crossbar #(
        .ADDR_W (ADDR_W),
        .DATA_W (DATA_W)
    ) u_port_crossbar (
        .owner_i              (owner),
        .busy_i               (busy),
        .c0_data_req_i        (c0_data_req_i),
        .c0_data_addr_i       (c0_data_addr_i),
        .c0_data_wr_en_i      (c0_data_wr_en_i),
        .c0_data_wr_data_i    (c0_data_wr_data_i),
        .c0_data_rd_data_o    (c0_data_rd_data_o),
        .c0_instr_req_i       (c0_instr_req_i),
        .c0_instr_addr_i      (c0_instr_addr_i),
        .c0_instr_rd_data_o   (c0_instr_rd_data_o),
        .c0_scalar_req_i      (c0_scalar_req_i),
        .c0_scalar_addr_i     (c0_scalar_addr_i),
        .c0_scalar_rd_data_o  (c0_scalar_rd_data_o),
        .c1_data_req_i        (c1_data_req_i),
        .c1_data_addr_i       (c1_data_addr_i),
        .c1_data_wr_en_i      (c1_data_wr_en_i),
        .c1_data_wr_data_i    (c1_data_wr_data_i),
        .c1_data_rd_data_o    (c1_data_rd_data_o),
        .c1_instr_req_i       (c1_instr_req_i),
        .c1_instr_addr_i      (c1_instr_addr_i),
        .c1_instr_rd_data_o   (c1_instr_rd_data_o),
        .c1_scalar_req_i      (c1_scalar_req_i),
        .c1_scalar_addr_i     (c1_scalar_addr_i),
        .c1_scalar_rd_data_o  (c1_scalar_rd_data_o),
        .mem_req_o            (mem_req_o),
        .mem_addr_o           (mem_addr_o),
        .mem_wr_en_o          (mem_wr_en_o),
        .mem_wr_data_o        (mem_wr_data_o),
        .mem_rd_data_i        (mem_rd_data_i),
        .instr_nvm_req_o      (instr_nvm_req_o),
        .instr_nvm_addr_o     (instr_nvm_addr_o),
        .instr_nvm_rd_data_i  (instr_nvm_rd_data_i),
        .scalar_nvm_req_o     (scalar_nvm_req_o),
        .scalar_nvm_addr_o    (scalar_nvm_addr_o),
        .scalar_nvm_rd_data_i (scalar_nvm_rd_data_i)
    );

endmodule

//--- source/port_crossbar.sv
//**********************************************************
// port crossbar
// partial connection, port k of the owner core to slave k,
// read data steered back to the owner only
//**********************************************************

`timescale 1ns/100ps

module port_crossbar #(
    parameter int ADDR_W = nib_pkg::NIB_ADDR_W,
    parameter int DATA_W = nib_pkg::NIB_DATA_W
) (
    input  nib_pkg::core_idx_t owner_i,
    input  logic              busy_i,

    // core 0 data port
    input  logic              c0_data_req_i,
    input  logic [ADDR_W-1:0] c0_data_addr_i,
    input  logic              c0_data_wr_en_i,
    input  logic [DATA_W-1:0] c0_data_wr_data_i,
    output logic [DATA_W-1:0] c0_data_rd_data_o,
    // core 0 instr port
    input  logic              c0_instr_req_i,
    input  logic [ADDR_W-1:0] c0_instr_addr_i,
    output logic [DATA_W-1:0] c0_instr_rd_data_o,
    // core 0 scalar port
    input  logic              c0_scalar_req_i,
    input  logic [ADDR_W-1:0] c0_scalar_addr_i,
    output logic [DATA_W-1:0] c0_scalar_rd_data_o,

    // core 1 data port
    input  logic              c1_data_req_i,
    input  logic [ADDR_W-1:0] c1_data_addr_i,
    input  logic              c1_data_wr_en_i,
    input  logic [DATA_W-1:0] c1_data_wr_data_i,
    output logic [DATA_W-1:0] c1_data_rd_data_o,
    // core 1 instr port
    input  logic              c1_instr_req_i,
    input  logic [ADDR_W-1:0] c1_instr_addr_i,
    output logic [DATA_W-1:0] c1_instr_rd_data_o,
    // core 1 scalar port
    input  logic              c1_scalar_req_i,
    input  logic [ADDR_W-1:0] c1_scalar_addr_i,
    output logic [DATA_W-1:0] c1_scalar_rd_data_o,

    // data memory
    output logic              mem_req_o,
    output logic [ADDR_W-1:0] mem_addr_o,
    output logic              mem_wr_en_o,
    output logic [DATA_W-1:0] mem_wr_data_o,
    input  logic [DATA_W-1:0] mem_rd_data_i,
    // instruction nvm
    output logic              instr_nvm_req_o,
    output logic [ADDR_W-1:0] instr_nvm_addr_o,
    input  logic [DATA_W-1:0] instr_nvm_rd_data_i,
    // scalar nvm
    output logic              scalar_nvm_req_o,
    output logic [ADDR_W-1:0] scalar_nvm_addr_o,
    input  logic [DATA_W-1:0] scalar_nvm_rd_data_i
);
    import nib_pkg::*;

    logic sel_c0;
    logic sel_c1;

    // one-hot core select, both low while idle
    assign sel_c0 = busy_i && (owner_i == CORE_0);
    assign sel_c1 = busy_i && (owner_i == CORE_1);

    // request path to the slaves, no register
    always_comb begin
        // idle bus drives zeros everywhere
        mem_req_o         = 1'b0;
        mem_addr_o        = '0;
        mem_wr_en_o       = 1'b0;
        mem_wr_data_o     = '0;
        instr_nvm_req_o   = 1'b0;
        instr_nvm_addr_o  = '0;
        scalar_nvm_req_o  = 1'b0;
        scalar_nvm_addr_o = '0;
        if (sel_c0) begin
            mem_req_o         = c0_data_req_i;
            mem_addr_o        = c0_data_addr_i;
            mem_wr_en_o       = c0_data_wr_en_i;
            mem_wr_data_o     = c0_data_wr_data_i;
            instr_nvm_req_o   = c0_instr_req_i;
            instr_nvm_addr_o  = c0_instr_addr_i;
            scalar_nvm_req_o  = c0_scalar_req_i;
            scalar_nvm_addr_o = c0_scalar_addr_i;
        end else if (sel_c1) begin
            mem_req_o         = c1_data_req_i;
            mem_addr_o        = c1_data_addr_i;
            mem_wr_en_o       = c1_data_wr_en_i;
            mem_wr_data_o     = c1_data_wr_data_i;
            instr_nvm_req_o   = c1_instr_req_i;
            instr_nvm_addr_o  = c1_instr_addr_i;
            scalar_nvm_req_o  = c1_scalar_req_i;
            scalar_nvm_addr_o = c1_scalar_addr_i;
        end
    end

    // read data back to the owner, zero for the other core
    assign c0_data_rd_data_o   = sel_c0 ? mem_rd_data_i        : '0;
    assign c0_instr_rd_data_o  = sel_c0 ? instr_nvm_rd_data_i  : '0;
    assign c0_scalar_rd_data_o = sel_c0 ? scalar_nvm_rd_data_i : '0;

    assign c1_data_rd_data_o   = sel_c1 ? mem_rd_data_i        : '0;
    assign c1_instr_rd_data_o  = sel_c1 ? instr_nvm_rd_data_i  : '0;
    assign c1_scalar_rd_data_o = sel_c1 ? scalar_nvm_rd_data_i : '0;

endmodule

//--- source/core_owner_arb.sv
//**********************************************************
// core owner arbiter
// sticky two-core arbitration of the whole bus, the owner
// keeps it while any of its ports requests
//**********************************************************

`timescale 1ns/100ps

module core_owner_arb (
    input  logic              clk,
    input  logic              rstn,
    // bit 0 data, bit 1 instr, bit 2 scalar
    input  logic [2:0]        c0_req_vec_i,
    input  logic [2:0]        c1_req_vec_i,
    output nib_pkg::core_idx_t owner_o,
    output logic              busy_o,
    output logic              c0_hold_o,
    output logic              c1_hold_o
);
    import nib_pkg::*;

    logic      c0_req;
    logic      c1_req;
    // last core that held the bus, decides who wins next
    core_idx_t last_owner;
    core_idx_t other_core;
    logic      last_req;
    logic      other_req;

    // any port of a core asks for the bus
    assign c0_req = |c0_req_vec_i;
    assign c1_req = |c1_req_vec_i;

    // the core that did not own the bus last
    assign other_core = (last_owner == CORE_0) ? CORE_1 : CORE_0;

    // requests seen from the last owner's side
    assign last_req  = (last_owner == CORE_0) ? c0_req : c1_req;
    assign other_req = (last_owner == CORE_0) ? c1_req : c0_req;

    // sticky priority to the last owner
    always_comb begin
        if (last_req) begin
            owner_o = last_owner;
            busy_o  = 1'b1;
        end else if (other_req) begin
            owner_o = other_core;
            busy_o  = 1'b1;
        end else begin
            // idle, owner value is a don't care here
            owner_o = last_owner;
            busy_o  = 1'b0;
        end
    end

    // a requesting core that does not own the bus must stall
    assign c0_hold_o = c0_req && (owner_o != CORE_0);
    assign c1_hold_o = c1_req && (owner_o != CORE_1);

    // remember the owner, keep it over idle cycles
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            last_owner <= CORE_0;
        end else if (busy_o) begin
            last_owner <= owner_o;
        end
    end

endmodule

//--- source/nib_pkg.sv
//**********************************************************
// nib shared definitions
// bus widths, core count and core index encoding
//**********************************************************

package nib_pkg;

    // one 32-bit word for every address
    parameter int NIB_ADDR_W = 32;

    // read and write data are one word too
    parameter int NIB_DATA_W = 32;

    // cores sharing the bus
    parameter int NIB_CORE_NUM = 2;

    // core index, wide enough for every core on the bus
    typedef logic [$clog2(NIB_CORE_NUM)-1:0] core_idx_t;

    // core 0 is also the owner after reset
    parameter core_idx_t CORE_0 = core_idx_t'(0);
    parameter core_idx_t CORE_1 = core_idx_t'(1);

endpackage
